// ==== project.f ====
+incdir+hw
hw/core_pkg.sv
hw/register_status.sv
hw/dispatch_unit.sv
hw/rs_slot.sv
hw/issue_unit.sv
hw/reorder_buffer.sv
hw/core_top.sv
bench/core_checker.sv
bench/core_tb.sv

// ==== bench/core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module core_tb;
  import core_pkg::*;

  localparam int NUM_INSTR      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * (`ROB_DEPTH + 4) + 200;
  localparam int DRAIN_CYCLES   = 4 * (`ROB_DEPTH + 4);  // A full ROB of one dependent chain

  logic    i_clk = 1'b0;
  logic    i_reset;
  logic    i_instr_valid;
  instr_t  i_instr;
  logic    o_stall;
  logic    o_commit_valid;
  commit_t o_commit;

  reg_value_t model_regs [`GPR_COUNT];
  commit_t    expected_q [$];
  int         errors = 0;
  int         checks = 0;
  int         commits = 0;
  int         stall_cycles = 0;
  int         cycle_count = 0;
  int         window_base = 0;
  int         burst_left = 0;

  core_top i_dut (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_instr_valid  (i_instr_valid),
    .i_instr        (i_instr),
    .o_stall        (o_stall),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

  bind reorder_buffer core_checker u_core_checker (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_count        (count),
    .i_full         (o_full),
    .i_alloc_valid  (i_alloc_valid),
    .i_commit_valid (o_commit_valid)
  );

  always #5 i_clk = ~i_clk;

  task automatic check_value(input string name, input reg_value_t expected,
                             input reg_value_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Registers are drawn from a small window that moves now and then, so chains are dense
  task automatic make_instr(output instr_t ins);
    if (burst_left == 0) begin
      window_base = $urandom_range(`GPR_COUNT - 4, 0);
      burst_left  = $urandom_range(24, 8);
    end
    burst_left--;
    ins.op  = ($urandom_range(2, 0) == 0) ? OP_LDI : alu_op_e'($urandom_range(4, 0));
    ins.rd  = gpr_index_t'(window_base + $urandom_range(3, 0));
    ins.rs1 = gpr_index_t'(window_base + $urandom_range(3, 0));
    ins.rs2 = gpr_index_t'(window_base + $urandom_range(3, 0));
    ins.imm = imm_t'($urandom);
  endtask

  // In-order reference, each result uses the newest earlier write of its sources
  task automatic model_accept(input instr_t ins);
    reg_value_t a;
    reg_value_t b;
    reg_value_t result;
    a = model_regs[ins.rs1];
    b = model_regs[ins.rs2];
    case (ins.op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      default: result = reg_value_t'(ins.imm);  // Load-immediate, zero extended
    endcase
    model_regs[ins.rd] = result;
    expected_q.push_back('{rd: ins.rd, value: result});
  endtask

  task automatic observe_commit();
    commit_t exp;
    if (o_commit_valid) begin
      assert (expected_q.size() != 0) else begin
        errors++;
        $display("ERROR: a commit appeared with no accepted instruction outstanding");
      end
      if (expected_q.size() != 0) begin
        exp = expected_q.pop_front();
        check_value($sformatf("commit %0d rd", commits), reg_value_t'(exp.rd),
                    reg_value_t'(o_commit.rd));
        check_value($sformatf("commit %0d value", commits), exp.value, o_commit.value);
        commits++;
      end
    end
  endtask

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("ERROR: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    instr_t cur;
    bit     pending;
    bit     held;
    int     accepted;
    int     drain;
    void'($urandom(41));
    pending = 1'b0;
    held = 1'b0;
    accepted = 0;
    drain = 0;
    cur = '0;
    for (int i = 0; i < `GPR_COUNT; i++) begin
      model_regs[i] = '0;
    end
    i_reset = 1'b1;
    i_instr_valid = 1'b0;
    i_instr = '0;
    repeat (3) @(negedge i_clk);
    i_reset = 1'b0;

    // Idle after reset, nothing may commit or stall before the first instruction
    repeat (3) begin
      @(negedge i_clk);
      check_value("idle stall", '0, reg_value_t'(o_stall));
      check_value("idle commit valid", '0, reg_value_t'(o_commit_valid));
    end

    while (accepted < NUM_INSTR) begin
      @(negedge i_clk);
      observe_commit();
      if (!pending) begin
        make_instr(cur);
        pending = 1'b1;
      end
      i_instr = cur;
      i_instr_valid = held ? 1'b1 : ($urandom_range(4, 0) != 0);  // A stalled one stays up
      // o_stall depends on state only, so it already shows the next edge's decision
      if (i_instr_valid && !o_stall) begin
        model_accept(cur);
        accepted++;
        pending = 1'b0;
        held = 1'b0;
      end else begin
        held = i_instr_valid;
        if (held) begin
          stall_cycles++;
        end
      end
      assert (expected_q.size() <= `ROB_DEPTH) else begin
        errors++;
        $display("ERROR: more than %0d instructions in flight", `ROB_DEPTH);
      end
    end

    @(negedge i_clk);
    observe_commit();
    i_instr_valid = 1'b0;
    while (expected_q.size() != 0 && drain < DRAIN_CYCLES) begin
      @(negedge i_clk);
      observe_commit();
      drain++;
    end
    repeat (10) begin  // Any late extra commit would show up here
      @(negedge i_clk);
      observe_commit();
    end
    assert (expected_q.size() == 0) else begin
      errors++;
      $display("ERROR: %0d accepted instructions never committed", expected_q.size());
    end

    $display("checks %0d, errors %0d, assertion failures %0d, commits %0d, stall cycles %0d",
             checks, errors, i_dut.u_reorder_buffer.u_core_checker.fail_count, commits,
             stall_cycles);
    if (errors == 0 && i_dut.u_reorder_buffer.u_core_checker.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module core_checker (
  input wire logic                        i_clk,
  input wire logic                        i_reset,
  input wire logic [$clog2(`ROB_DEPTH):0] i_count,
  input wire logic                        i_full,
  input wire logic                        i_alloc_valid,
  input wire logic                        i_commit_valid
);

  int unsigned fail_count = 0;  // Number of failed properties so far

  // The occupancy counter must stay within the buffer
  a_count_bound: assert property (
    @(posedge i_clk) disable iff (i_reset) i_count <= `ROB_DEPTH
  ) else begin
    fail_count++;
    $error("ROB occupancy count exceeds the buffer depth");
  end

  // A reset cycle leaves the commit output low on the following edge
  a_no_commit_in_reset: assert property (
    @(posedge i_clk) i_reset |=> !i_commit_valid
  ) else begin
    fail_count++;
    $error("Commit output is valid while the core is in reset");
  end

  a_no_alloc_when_full: assert property (
    @(posedge i_clk) disable iff (i_reset) !(i_alloc_valid && i_full)
  ) else begin
    fail_count++;
    $error("ROB entry allocated while the buffer is full");
  end

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module core_top (
  input  wire logic             i_clk,
  input  wire logic             i_reset,
  input  wire logic             i_instr_valid,
  input  wire core_pkg::instr_t i_instr,
  output logic                  o_stall,
  output logic                  o_commit_valid,
  output core_pkg::commit_t     o_commit
);
  import core_pkg::*;

  rs_op_t                    rs1_entry;
  rs_op_t                    rs2_entry;
  rob_tag_t                  query_tag1;
  rob_tag_t                  query_tag2;
  logic                      rob_done1;
  logic                      rob_done2;
  reg_value_t                rob_value1;
  reg_value_t                rob_value2;
  logic                      rob_full;
  rob_tag_t                  rob_tail;
  rob_tag_t                  commit_tag;
  logic                      alloc_valid;
  cdb_t                      cdb;
  rs_entry_t                 new_entry;
  logic [`RS_COUNT-1:0]      slot_write;
  logic [`RS_COUNT-1:0]      slot_busy;
  logic [`RS_COUNT-1:0]      slot_ready;
  logic [`RS_COUNT-1:0]      grant;
  rs_entry_t [`RS_COUNT-1:0] slot_entries;

  // Rename uses the allocate strobe and the ROB tail of the same cycle
  register_status u_register_status (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_rs1          (i_instr.rs1),
    .i_rs2          (i_instr.rs2),
    .o_rs1_entry    (rs1_entry),
    .o_rs2_entry    (rs2_entry),
    .i_rename_valid (alloc_valid),
    .i_rename_rd    (i_instr.rd),
    .i_rename_tag   (rob_tail),
    .i_commit_valid (o_commit_valid),
    .i_commit_rd    (o_commit.rd),
    .i_commit_tag   (commit_tag),
    .i_commit_value (o_commit.value)
  );

  dispatch_unit u_dispatch_unit (
    .i_instr_valid    (i_instr_valid),
    .i_instr          (i_instr),
    .i_rs1_entry      (rs1_entry),
    .i_rs2_entry      (rs2_entry),
    .o_rob_query_tag1 (query_tag1),
    .o_rob_query_tag2 (query_tag2),
    .i_rob_done1      (rob_done1),
    .i_rob_done2      (rob_done2),
    .i_rob_value1     (rob_value1),
    .i_rob_value2     (rob_value2),
    .i_cdb            (cdb),
    .i_rob_full       (rob_full),
    .i_rob_tail       (rob_tail),
    .i_slot_busy      (slot_busy),
    .o_slot_write     (slot_write),
    .o_entry          (new_entry),
    .o_alloc_valid    (alloc_valid),
    .o_stall          (o_stall)
  );

  for (genvar i = 0; i < `RS_COUNT; i++) begin : g_slot
    rs_slot u_rs_slot (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_write (slot_write[i]),
      .i_entry (new_entry),
      .i_cdb   (cdb),
      .i_grant (grant[i]),
      .o_busy  (slot_busy[i]),
      .o_ready (slot_ready[i]),
      .o_entry (slot_entries[i])
    );
  end

  issue_unit u_issue_unit (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_ready   (slot_ready),
    .i_entries (slot_entries),
    .o_grant   (grant),
    .o_cdb     (cdb)
  );

  reorder_buffer u_reorder_buffer (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_alloc_valid  (alloc_valid),
    .i_alloc_rd     (i_instr.rd),
    .o_tail         (rob_tail),
    .o_full         (rob_full),
    .i_query_tag1   (query_tag1),
    .i_query_tag2   (query_tag2),
    .o_done1        (rob_done1),
    .o_done2        (rob_done2),
    .o_value1       (rob_value1),
    .o_value2       (rob_value2),
    .i_cdb          (cdb),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .o_commit_tag   (commit_tag)
  );

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module reorder_buffer (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset,
  input  wire logic                 i_alloc_valid,
  input  wire core_pkg::gpr_index_t i_alloc_rd,
  output core_pkg::rob_tag_t        o_tail,
  output logic                      o_full,
  input  wire core_pkg::rob_tag_t   i_query_tag1,
  input  wire core_pkg::rob_tag_t   i_query_tag2,
  output logic                      o_done1,
  output logic                      o_done2,
  output core_pkg::reg_value_t      o_value1,
  output core_pkg::reg_value_t      o_value2,
  input  wire core_pkg::cdb_t       i_cdb,
  output logic                      o_commit_valid,
  output core_pkg::commit_t         o_commit,
  output core_pkg::rob_tag_t        o_commit_tag
);
  import core_pkg::*;

  gpr_index_t                  rd_q    [`ROB_DEPTH];
  reg_value_t                  value_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0]       done;
  rob_tag_t                    head;
  rob_tag_t                    tail;
  logic [$clog2(`ROB_DEPTH):0] count;  // One bit wider than a tag to tell full from empty
  logic                        head_hit;
  logic                        commit_fire;
  reg_value_t                  commit_value;

  // The head may finish on the bus in the same cycle that it commits
  assign head_hit     = i_cdb.valid && (i_cdb.tag == head);
  assign commit_fire  = (count != '0) && (done[head] || head_hit);
  assign commit_value = done[head] ? value_q[head] : i_cdb.value;

  assign o_tail = tail;
  assign o_full = (count == `ROB_DEPTH);

  // Done is kept past commit, so a register still marked busy for one
  // more cycle can read its value here
  assign o_done1  = done[i_query_tag1];
  assign o_done2  = done[i_query_tag2];
  assign o_value1 = value_q[i_query_tag1];
  assign o_value2 = value_q[i_query_tag2];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      done           <= '0;
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= commit_fire;
      if (i_cdb.valid) begin
        done[i_cdb.tag] <= 1'b1;
      end
      if (i_alloc_valid) begin
        done[tail] <= 1'b0;  // Tail is never the tag on the bus
        tail       <= tail + 1'b1;
      end
      if (commit_fire) begin
        head <= head + 1'b1;
      end
      if (i_alloc_valid && !commit_fire) begin
        count <= count + 1'b1;
      end else if (!i_alloc_valid && commit_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alloc_valid) begin
      rd_q[tail] <= i_alloc_rd;
    end
    if (i_cdb.valid) begin
      value_q[i_cdb.tag] <= i_cdb.value;
    end
    if (commit_fire) begin
      o_commit     <= '{rd: rd_q[head], value: commit_value};
      o_commit_tag <= head;  // Lets the register file apply the stale-tag rule
    end
  end

endmodule

`default_nettype wire

// ==== hw/issue_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module issue_unit (
  input  wire logic                                 i_clk,
  input  wire logic                                 i_reset,
  input  wire logic [`RS_COUNT-1:0]                 i_ready,
  input  wire core_pkg::rs_entry_t [`RS_COUNT-1:0]  i_entries,
  output logic [`RS_COUNT-1:0]                      o_grant,
  output core_pkg::cdb_t                            o_cdb
);
  import core_pkg::*;

  rs_entry_t  sel;
  reg_value_t result;
  logic       cdb_valid_q;
  rob_tag_t   cdb_tag_q;
  reg_value_t cdb_value_q;

  assign o_grant = i_ready & (~i_ready + 1'b1);  // Lowest ready slot wins

  // Grant is one-hot so at most one entry is selected
  always_comb begin
    sel = '0;
    for (int i = 0; i < `RS_COUNT; i++) begin
      if (o_grant[i]) begin
        sel = i_entries[i];
      end
    end
  end

  always_comb begin
    case (sel.op)
      OP_ADD:  result = sel.op1.value + sel.op2.value;  // Wraps at 64 bits
      OP_SUB:  result = sel.op1.value - sel.op2.value;
      OP_AND:  result = sel.op1.value & sel.op2.value;
      OP_OR:   result = sel.op1.value | sel.op2.value;
      OP_XOR:  result = sel.op1.value ^ sel.op2.value;
      OP_LDI:  result = sel.op1.value;
      default: result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cdb_valid_q <= 1'b0;
    end else begin
      cdb_valid_q <= |i_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    if (|i_ready) begin
      cdb_tag_q   <= sel.dest;
      cdb_value_q <= result;
    end
  end

  assign o_cdb = '{valid: cdb_valid_q, tag: cdb_tag_q, value: cdb_value_q};

endmodule

`default_nettype wire

// ==== hw/rs_slot.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_slot (
  input  wire logic                i_clk,
  input  wire logic                i_reset,
  input  wire logic                i_write,
  input  wire core_pkg::rs_entry_t i_entry,
  input  wire core_pkg::cdb_t      i_cdb,
  input  wire logic                i_grant,
  output logic                     o_busy,
  output logic                     o_ready,
  output core_pkg::rs_entry_t      o_entry
);
  import core_pkg::*;

  rs_entry_t entry_q;
  rs_entry_t entry_next;

  // Fills a waiting operand when its producer broadcasts
  function automatic rs_op_t capture(input rs_op_t op, input cdb_t cdb);
    rs_op_t result;
    result = op;
    if (!op.valid && cdb.valid && cdb.tag == op.tag) begin
      result.valid = 1'b1;
      result.value = cdb.value;
    end
    return result;
  endfunction

  always_comb begin
    entry_next     = i_write ? i_entry : entry_q;  // A new entry may also capture right away
    entry_next.op1 = capture(entry_next.op1, i_cdb);
    entry_next.op2 = capture(entry_next.op2, i_cdb);
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      entry_q <= '0;
    end else begin
      entry_q <= entry_next;
      if (i_grant) begin
        entry_q.busy <= 1'b0;  // Operands are already latched by the issue unit's bus register
      end
    end
  end

  assign o_busy  = entry_q.busy;
  assign o_ready = entry_q.busy && entry_q.op1.valid && entry_q.op2.valid;
  assign o_entry = entry_q;

endmodule

`default_nettype wire

// ==== hw/dispatch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module dispatch_unit (
  input  wire logic                    i_instr_valid,
  input  wire core_pkg::instr_t        i_instr,
  input  wire core_pkg::rs_op_t        i_rs1_entry,
  input  wire core_pkg::rs_op_t        i_rs2_entry,
  output core_pkg::rob_tag_t           o_rob_query_tag1,
  output core_pkg::rob_tag_t           o_rob_query_tag2,
  input  wire logic                    i_rob_done1,
  input  wire logic                    i_rob_done2,
  input  wire core_pkg::reg_value_t    i_rob_value1,
  input  wire core_pkg::reg_value_t    i_rob_value2,
  input  wire core_pkg::cdb_t          i_cdb,
  input  wire logic                    i_rob_full,
  input  wire core_pkg::rob_tag_t      i_rob_tail,
  input  wire logic [`RS_COUNT-1:0]    i_slot_busy,
  output logic [`RS_COUNT-1:0]         o_slot_write,
  output core_pkg::rs_entry_t          o_entry,
  output logic                         o_alloc_valid,
  output logic                         o_stall
);
  import core_pkg::*;

  logic                 accept;
  logic [`RS_COUNT-1:0] free_slots;
  rs_op_t               op1;
  rs_op_t               op2;

  // Operand priority is register file, then finished ROB entry, then the bus
  function automatic rs_op_t resolve(input rs_op_t rf, input logic rob_done,
                                     input reg_value_t rob_value, input cdb_t cdb);
    rs_op_t op;
    op = rf;
    if (!rf.valid) begin
      if (rob_done) begin
        op.valid = 1'b1;
        op.value = rob_value;
      end else if (cdb.valid && cdb.tag == rf.tag) begin
        op.valid = 1'b1;  // Result is on the bus this very cycle
        op.value = cdb.value;
      end
    end
    return op;
  endfunction

  assign o_rob_query_tag1 = i_rs1_entry.tag;
  assign o_rob_query_tag2 = i_rs2_entry.tag;

  assign o_stall       = i_rob_full || (&i_slot_busy);
  assign accept        = i_instr_valid && !o_stall;
  assign o_alloc_valid = accept;  // Also serves as the rename strobe at the top level

  // Lowest free slot by isolating the lowest set bit
  assign free_slots   = ~i_slot_busy;
  assign o_slot_write = accept ? (free_slots & (~free_slots + 1'b1)) : '0;

  always_comb begin
    op1 = resolve(i_rs1_entry, i_rob_done1, i_rob_value1, i_cdb);
    op2 = resolve(i_rs2_entry, i_rob_done2, i_rob_value2, i_cdb);
    if (i_instr.op == OP_LDI) begin
      // Load-immediate ignores its sources and passes op1 through the ALU
      op1 = '{valid: 1'b1, tag: '0, value: reg_value_t'(i_instr.imm)};
      op2 = '{valid: 1'b1, tag: '0, value: '0};
    end
  end

  assign o_entry = '{busy: 1'b1, op: i_instr.op, dest: i_rob_tail, op1: op1, op2: op2};

endmodule

`default_nettype wire

// ==== hw/register_status.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module register_status (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset,
  input  wire core_pkg::gpr_index_t i_rs1,
  input  wire core_pkg::gpr_index_t i_rs2,
  output core_pkg::rs_op_t          o_rs1_entry,
  output core_pkg::rs_op_t          o_rs2_entry,
  input  wire logic                 i_rename_valid,
  input  wire core_pkg::gpr_index_t i_rename_rd,
  input  wire core_pkg::rob_tag_t   i_rename_tag,
  input  wire logic                 i_commit_valid,
  input  wire core_pkg::gpr_index_t i_commit_rd,
  input  wire core_pkg::rob_tag_t   i_commit_tag,
  input  wire core_pkg::reg_value_t i_commit_value
);
  import core_pkg::*;

  reg_value_t            regs [`GPR_COUNT];
  rob_tag_t              tags [`GPR_COUNT];
  logic [`GPR_COUNT-1:0] busy;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy <= '0;
      for (int i = 0; i < `GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (i_commit_valid) begin
        regs[i_commit_rd] <= i_commit_value;  // Architectural value is always updated
        // A younger rename owns the register when the tags differ
        if (tags[i_commit_rd] == i_commit_tag) begin
          busy[i_commit_rd] <= 1'b0;
        end
      end
      if (i_rename_valid) begin
        busy[i_rename_rd] <= 1'b1;  // Placed last so it beats a commit to the same register
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rename_valid) begin
      tags[i_rename_rd] <= i_rename_tag;
    end
  end

  // Valid on a read port means the register is not waiting on any ROB entry
  assign o_rs1_entry = '{valid: !busy[i_rs1], tag: tags[i_rs1], value: regs[i_rs1]};
  assign o_rs2_entry = '{valid: !busy[i_rs2], tag: tags[i_rs2], value: regs[i_rs2]};

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

`include "core_macros.svh"

package core_pkg;

  typedef logic [`REG_WIDTH-1:0]         reg_value_t;
  typedef logic [$clog2(`GPR_COUNT)-1:0] gpr_index_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;
  typedef logic [`IMM_WIDTH-1:0]         imm_t;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_LDI = 3'd5  // Result is the zero-extended immediate
  } alu_op_e;

  typedef struct packed {
    alu_op_e    op;
    gpr_index_t rd;
    gpr_index_t rs1;
    gpr_index_t rs2;
    imm_t       imm;
  } instr_t;

  // Value is only meaningful once valid is set, until then tag names the producer
  typedef struct packed {
    logic       valid;
    rob_tag_t   tag;
    reg_value_t value;
  } rs_op_t;

  typedef struct packed {
    logic     busy;
    alu_op_e  op;
    rob_tag_t dest;  // ROB entry that receives the result
    rs_op_t   op1;
    rs_op_t   op2;
  } rs_entry_t;

  typedef struct packed {
    logic       valid;
    rob_tag_t   tag;
    reg_value_t value;
  } cdb_t;

  typedef struct packed {
    gpr_index_t rd;
    reg_value_t value;
  } commit_t;

endpackage

`default_nettype wire

// ==== hw/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath sizes
`define REG_WIDTH 64
`define GPR_COUNT 32
`define IMM_WIDTH 16

// Out-of-order window
`define RS_COUNT  4  // Reservation-station slots, one bit each in the slot masks
`define ROB_DEPTH 8  // Must stay a power of two so the ROB pointers wrap by themselves

// The ROB tag width is derived from ROB_DEPTH in the package, so changing
// the depth here resizes every tag field in the core at once

`endif
